//--- design/apb_mem_port.sv
// apb slave that turns host transfers into shared ram requests
`timescale 1ns/100ps

module apb_mem_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  soc_bus_pkg::addr_t    paddr,
    input  rv_isa_pkg::word_t     pwdata,
    output rv_isa_pkg::word_t     prdata,
    output logic                  pready,
    output soc_bus_pkg::mem_req_t mem_req,
    input  soc_bus_pkg::mem_rsp_t mem_rsp
);
    logic access;
    logic done;

    assign access = psel && penable;

    // set at ack, cleared once the access phase ends
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else if (mem_rsp.ack) begin
            done <= 1'b1;
        end else if (!access) begin
            done <= 1'b0;
        end
    end

    always_comb begin
        mem_req.req   = access && !done;
        mem_req.we    = pwrite;
        mem_req.addr  = paddr;
        mem_req.wdata = pwdata;
    end

    // wait states until the ram answers
    assign pready = mem_rsp.ack;
    assign prdata = mem_rsp.rdata;

endmodule

//--- design/data_ram.sv
// single-port word ram, registered read data and a one-cycle ack
`timescale 1ns/100ps

module data_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  soc_bus_pkg::mem_req_t req,
    output soc_bus_pkg::mem_rsp_t rsp
);
    rv_isa_pkg::word_t     mem [soc_bus_pkg::RAM_WORDS];
    rv_isa_pkg::word_t     rdata_q;
    soc_bus_pkg::ram_idx_t idx;
    logic                  ack_q;
    logic                  take;

    assign idx = req.addr[11:2];
    // the ack cycle itself never starts a transfer
    assign take = req.req && !ack_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (req.we) begin
                mem[idx] <= req.wdata;
            end
            rdata_q <= mem[idx];
        end
    end

    assign rsp.ack   = ack_q;
    assign rsp.rdata = rdata_q;

endmodule

//--- design/mem_arbiter.sv
// fixed priority arbiter for the shared ram, host port ahead of the core
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  soc_bus_pkg::mem_req_t host_req,
    output soc_bus_pkg::mem_rsp_t host_rsp,
    input  soc_bus_pkg::mem_req_t core_req,
    output soc_bus_pkg::mem_rsp_t core_rsp,
    output soc_bus_pkg::mem_req_t ram_req,
    input  soc_bus_pkg::mem_rsp_t ram_rsp
);
    typedef enum logic [1:0] {
        IDLE,
        HOST,
        CORE
    } owner_e;

    owner_e owner;
    logic   grant_host;
    logic   grant_core;

    // idle grants straight away so an idle ram acks after one cycle
    always_comb begin
        grant_host = 1'b0;
        grant_core = 1'b0;
        case (owner)
            IDLE: begin
                grant_host = host_req.req;
                grant_core = !host_req.req && core_req.req;
            end
            HOST:    grant_host = 1'b1;
            CORE:    grant_core = 1'b1;
            default: grant_host = 1'b0;
        endcase
    end

    always_comb begin
        ram_req = '0;
        if (grant_host) begin
            ram_req = host_req;
        end else if (grant_core) begin
            ram_req = core_req;
        end
    end

    // grant stays locked until the owner's ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner <= IDLE;
        end else begin
            case (owner)
                IDLE: begin
                    if (grant_host) begin
                        owner <= HOST;
                    end else if (grant_core) begin
                        owner <= CORE;
                    end
                end
                default: begin
                    if (ram_rsp.ack) begin
                        owner <= IDLE;
                    end
                end
            endcase
        end
    end

    assign host_rsp.ack   = ram_rsp.ack && (owner == HOST);
    assign host_rsp.rdata = ram_rsp.rdata;
    assign core_rsp.ack   = ram_rsp.ack && (owner == CORE);
    assign core_rsp.rdata = ram_rsp.rdata;

endmodule

//--- design/rv_core.sv
// multi-cycle rv32i subset core with fetch, execute and memory phases
`timescale 1ns/100ps

module rv_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    output soc_bus_pkg::mem_req_t mem_req,
    input  soc_bus_pkg::mem_rsp_t mem_rsp,
    output rv_isa_pkg::word_t     out_data,
    output logic                  out_valid,
    output logic                  halted,
    output soc_bus_pkg::addr_t    pc
);
    rv_isa_pkg::core_state_e state;
    rv_isa_pkg::instr_t      instr_q;
    rv_isa_pkg::instr_t      instr;

    // request registers
    logic                    req_q;
    logic                    we_q;
    soc_bus_pkg::addr_t      addr_q;
    rv_isa_pkg::word_t       wdata_q;

    // decoded fields
    rv_isa_pkg::opcode_e     opcode;
    rv_isa_pkg::funct3_t     funct3;
    rv_isa_pkg::op_funct_t   op_funct;
    rv_isa_pkg::reg_sel_t    rd_sel;
    rv_isa_pkg::reg_sel_t    rs1_sel;
    rv_isa_pkg::reg_sel_t    rs2_sel;
    rv_isa_pkg::word_t       imm_i;
    rv_isa_pkg::word_t       imm_s;
    rv_isa_pkg::word_t       imm_b;
    rv_isa_pkg::word_t       imm_u;

    rv_isa_pkg::word_t       rs1_data;
    rv_isa_pkg::word_t       rs2_data;
    rv_isa_pkg::word_t       alu_result;
    soc_bus_pkg::addr_t      eff_addr;
    soc_bus_pkg::addr_t      next_pc;
    logic                    exec_done;
    logic                    br_taken;
    logic                    to_mem;
    logic                    to_halt;

    logic                    wr_en;
    rv_isa_pkg::word_t       wr_data;

    // fetched word in EXEC, latched word in MEM
    assign instr = (state == rv_isa_pkg::MEM) ? instr_q : mem_rsp.rdata;

    assign opcode   = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign op_funct = {instr[31:25], instr[14:12]};
    assign rd_sel   = instr[11:7];
    assign rs1_sel  = instr[19:15];
    assign rs2_sel  = instr[24:20];
    assign imm_i    = {{20{instr[31]}}, instr[31:20]};
    assign imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u    = {instr[31:12], 12'b0};

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (rd_sel),
        .wr_data  (wr_data)
    );

    always_comb begin
        case (op_funct)
            rv_isa_pkg::ADD:  alu_result = rs1_data + rs2_data;
            rv_isa_pkg::SUB:  alu_result = rs1_data - rs2_data;
            rv_isa_pkg::SLL:  alu_result = rs1_data << rs2_data[4:0];
            rv_isa_pkg::SLT:  alu_result = {31'b0, $signed(rs1_data) < $signed(rs2_data)};
            rv_isa_pkg::SLTU: alu_result = {31'b0, rs1_data < rs2_data};
            rv_isa_pkg::XOR:  alu_result = rs1_data ^ rs2_data;
            rv_isa_pkg::SRL:  alu_result = rs1_data >> rs2_data[4:0];
            rv_isa_pkg::SRA:  alu_result = $unsigned($signed(rs1_data) >>> rs2_data[4:0]);
            rv_isa_pkg::OR:   alu_result = rs1_data | rs2_data;
            rv_isa_pkg::AND:  alu_result = rs1_data & rs2_data;
            rv_isa_pkg::MUL:  alu_result = rs1_data * rs2_data;
            default:          alu_result = '0;
        endcase
    end

    assign exec_done = (state == rv_isa_pkg::EXEC) && mem_rsp.ack;
    assign eff_addr  = rs1_data + ((opcode == rv_isa_pkg::STORE) ? imm_s : imm_i);
    assign br_taken  = ((funct3 == rv_isa_pkg::BEQ) && (rs1_data == rs2_data)) ||
                       ((funct3 == rv_isa_pkg::BNE) && (rs1_data != rs2_data));

    // what EXEC does with the fetched word
    always_comb begin
        next_pc = pc + 32'd4;
        to_mem  = 1'b0;
        to_halt = 1'b0;
        case (opcode)
            rv_isa_pkg::OPIMM, rv_isa_pkg::OP, rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: begin
            end
            rv_isa_pkg::BRANCH: begin
                if (br_taken) begin
                    next_pc = pc + imm_b;
                end
            end
            rv_isa_pkg::LOAD: to_mem = 1'b1;
            rv_isa_pkg::STORE: begin
                if (eff_addr == soc_bus_pkg::HALT_ADDR) begin
                    to_halt = 1'b1;
                end else if (eff_addr != soc_bus_pkg::OUT_ADDR) begin
                    to_mem = 1'b1;
                end
            end
            // unknown opcode stops the core
            default: to_halt = 1'b1;
        endcase
    end

    // register write back
    always_comb begin
        wr_en   = 1'b0;
        wr_data = alu_result;
        if (exec_done) begin
            case (opcode)
                rv_isa_pkg::OPIMM: begin
                    wr_en   = (funct3 == rv_isa_pkg::ADDI);
                    wr_data = rs1_data + imm_i;
                end
                rv_isa_pkg::OP:    wr_en = 1'b1;
                rv_isa_pkg::LUI: begin
                    wr_en   = 1'b1;
                    wr_data = imm_u;
                end
                rv_isa_pkg::AUIPC: begin
                    wr_en   = 1'b1;
                    wr_data = pc + imm_u;
                end
                default: wr_en = 1'b0;
            endcase
        end else if ((state == rv_isa_pkg::MEM) && mem_rsp.ack &&
                     (opcode == rv_isa_pkg::LOAD)) begin
            wr_en   = 1'b1;
            wr_data = mem_rsp.rdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= rv_isa_pkg::FETCH;
            pc    <= '0;
            req_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            case (state)
                rv_isa_pkg::FETCH: begin
                    if (run) begin
                        req_q <= 1'b1;
                        we_q  <= 1'b0;
                        state <= rv_isa_pkg::EXEC;
                    end
                end
                rv_isa_pkg::EXEC: begin
                    if (mem_rsp.ack) begin
                        if (to_halt) begin
                            req_q <= 1'b0;
                            state <= rv_isa_pkg::HALTED;
                        end else if (to_mem) begin
                            // data request follows the fetch ack directly
                            req_q <= 1'b1;
                            we_q  <= (opcode == rv_isa_pkg::STORE);
                            state <= rv_isa_pkg::MEM;
                        end else begin
                            req_q <= 1'b0;
                            pc    <= next_pc;
                            state <= rv_isa_pkg::FETCH;
                        end
                    end
                end
                rv_isa_pkg::MEM: begin
                    if (mem_rsp.ack) begin
                        req_q <= 1'b0;
                        we_q  <= 1'b0;
                        pc    <= pc + 32'd4;
                        state <= rv_isa_pkg::FETCH;
                    end
                end
                default: begin
                    req_q <= 1'b0;
                end
            endcase
        end
    end

    // address, write data and instruction latch
    always_ff @(posedge clk) begin
        if (state == rv_isa_pkg::FETCH) begin
            addr_q <= pc;
        end else if (exec_done) begin
            addr_q  <= eff_addr;
            wdata_q <= rs2_data;
            instr_q <= mem_rsp.rdata;
        end
    end

    always_comb begin
        mem_req.req   = req_q;
        mem_req.we    = we_q;
        mem_req.addr  = addr_q;
        mem_req.wdata = wdata_q;
    end

    assign out_valid = exec_done && (opcode == rv_isa_pkg::STORE) &&
                       (eff_addr == soc_bus_pkg::OUT_ADDR);
    assign out_data  = rs2_data;
    assign halted    = (state == rv_isa_pkg::HALTED);

endmodule

//--- design/rv_isa_pkg.sv
// rv32i subset encodings and core types shared by the processor blocks
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_sel_t;
    typedef logic [2:0] funct3_t;
    typedef logic [9:0] op_funct_t;

    localparam int NUM_REGS = 32;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    localparam funct3_t ADDI = 3'b000;
    localparam funct3_t BEQ  = 3'b000;
    localparam funct3_t BNE  = 3'b001;

    // OP functions as {funct7, funct3}
    localparam op_funct_t ADD  = 10'b0000000_000;
    localparam op_funct_t SUB  = 10'b0100000_000;
    localparam op_funct_t SLL  = 10'b0000000_001;
    localparam op_funct_t SLT  = 10'b0000000_010;
    localparam op_funct_t SLTU = 10'b0000000_011;
    localparam op_funct_t XOR  = 10'b0000000_100;
    localparam op_funct_t SRL  = 10'b0000000_101;
    localparam op_funct_t SRA  = 10'b0100000_101;
    localparam op_funct_t OR   = 10'b0000000_110;
    localparam op_funct_t AND  = 10'b0000000_111;
    // rv32m multiply, low word only
    localparam op_funct_t MUL  = 10'b0000001_000;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALTED
    } core_state_e;

endpackage

//--- design/rv_regfile.sv
// integer register file, two async read ports and one write port, x0 reads zero
`timescale 1ns/100ps

module rv_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_isa_pkg::reg_sel_t rs1_sel,
    input  rv_isa_pkg::reg_sel_t rs2_sel,
    output rv_isa_pkg::word_t    rs1_data,
    output rv_isa_pkg::word_t    rs2_data,
    input  logic                 wr_en,
    input  rv_isa_pkg::reg_sel_t wr_sel,
    input  rv_isa_pkg::word_t    wr_data
);
    rv_isa_pkg::word_t regs [rv_isa_pkg::NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_en && (wr_sel != '0)) begin
            // x0 never written
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

endmodule

//--- design/rv_soc_top.sv
// soc top level with core, apb host port, arbiter and shared ram
`timescale 1ns/100ps

module rv_soc_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  soc_bus_pkg::addr_t paddr,
    input  rv_isa_pkg::word_t  pwdata,
    output rv_isa_pkg::word_t  prdata,
    output logic               pready,
    output logic               pslverr,
    output rv_isa_pkg::word_t  out_data,
    output logic               out_valid,
    output logic               halted,
    output soc_bus_pkg::addr_t pc
);
    soc_bus_pkg::mem_req_t host_req;
    soc_bus_pkg::mem_rsp_t host_rsp;
    soc_bus_pkg::mem_req_t core_req;
    soc_bus_pkg::mem_rsp_t core_rsp;
    soc_bus_pkg::mem_req_t ram_req;
    soc_bus_pkg::mem_rsp_t ram_rsp;

    // no error responses on the host port
    assign pslverr = 1'b0;

    rv_core u_core (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .mem_req   (core_req),
        .mem_rsp   (core_rsp),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted),
        .pc        (pc)
    );

    apb_mem_port u_apb (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .mem_req (host_req),
        .mem_rsp (host_rsp)
    );

    mem_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .ram_req  (ram_req),
        .ram_rsp  (ram_rsp)
    );

    data_ram u_ram (
        .clk (clk),
        .rst (rst),
        .req (ram_req),
        .rsp (ram_rsp)
    );

endmodule

//--- design/soc_bus_pkg.sv
// internal memory bus types, address map and ram sizing for the soc
package soc_bus_pkg;

    typedef logic [31:0] addr_t;

    localparam int RAM_WORDS = 1024;

    // word index into the ram, taken from addr[11:2]
    typedef logic [$clog2(RAM_WORDS)-1:0] ram_idx_t;

    // store-only mmio locations seen by the core
    localparam addr_t OUT_ADDR  = 32'd1000;
    localparam addr_t HALT_ADDR = 32'd1004;

    // held by the requester until ack
    typedef struct packed {
        logic                req;
        logic                we;
        addr_t               addr;
        rv_isa_pkg::word_t   wdata;
    } mem_req_t;

    // ack is a single-cycle pulse, rdata valid with it
    typedef struct packed {
        logic                ack;
        rv_isa_pkg::word_t   rdata;
    } mem_rsp_t;

endpackage

//--- files.f
+incdir+tb
design/rv_isa_pkg.sv
design/soc_bus_pkg.sv
design/rv_regfile.sv
design/rv_core.sv
design/mem_arbiter.sv
design/data_ram.sv
design/apb_mem_port.sv
design/rv_soc_top.sv
tb/tb_rv_soc.sv

//--- run.sh
#!/usr/bin/env bash
# build the soc testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module tb_rv_soc -f files.f -o tb_rv_soc \
    && ./obj_dir/tb_rv_soc | tee sim.log \
    || { echo "build or run failed"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log && { echo "test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no pass result in log"; exit 1; }
exit 0

//--- tb/tb_rv_model.svh
// instruction-set reference model and program builder for the soc testbench
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

rv_isa_pkg::word_t  model_mem [soc_bus_pkg::RAM_WORDS];
rv_isa_pkg::word_t  exp_out[$];
soc_bus_pkg::addr_t model_pc;
int                 prog_len;

function automatic void emit(input rv_isa_pkg::instr_t w);
    model_mem[prog_len] = w;
    prog_len++;
endfunction

function automatic rv_isa_pkg::instr_t enc_r(input logic [9:0] f, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
    return {f[9:3], rs2, rs1, f[2:0], rd, rv_isa_pkg::OP};
endfunction

function automatic rv_isa_pkg::instr_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

// word store, base rs1 and data rs2
function automatic rv_isa_pkg::instr_t enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::STORE};
endfunction

function automatic rv_isa_pkg::instr_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::BRANCH};
endfunction

function automatic rv_isa_pkg::instr_t enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

function automatic rv_isa_pkg::word_t alu_ref(input logic [9:0] f, input rv_isa_pkg::word_t a,
                                              input rv_isa_pkg::word_t b);
    case (f)
        rv_isa_pkg::ADD:  return a + b;
        rv_isa_pkg::SUB:  return a - b;
        rv_isa_pkg::SLL:  return a << b[4:0];
        rv_isa_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rv_isa_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
        rv_isa_pkg::XOR:  return a ^ b;
        rv_isa_pkg::SRL:  return a >> b[4:0];
        rv_isa_pkg::SRA:  return $signed(a) >>> b[4:0];
        rv_isa_pkg::OR:   return a | b;
        rv_isa_pkg::AND:  return a & b;
        rv_isa_pkg::MUL:  return a * b;
        default:          return 32'd0;
    endcase
endfunction

// runs model_mem from pc 0, returns 1 when the program halts
function automatic bit run_model();
    rv_isa_pkg::word_t x [32];
    rv_isa_pkg::word_t w;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t r;
    rv_isa_pkg::word_t ea;
    rv_isa_pkg::word_t imm_i;
    rv_isa_pkg::word_t imm_b;
    soc_bus_pkg::addr_t p;
    soc_bus_pkg::addr_t p_next;
    logic wr;
    x = '{default: '0};
    p = '0;
    exp_out.delete();
    for (int n = 0; n < 4000; n++) begin
        w      = model_mem[p[11:2]];
        a      = x[w[19:15]];
        b      = x[w[24:20]];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        ea     = a + {{20{w[31]}}, w[31:25], w[11:7]};
        p_next = p + 32'd4;
        wr     = 1'b1;
        r      = '0;
        case (w[6:0])
            rv_isa_pkg::OPIMM: r = a + imm_i;
            rv_isa_pkg::OP:    r = alu_ref({w[31:25], w[14:12]}, a, b);
            rv_isa_pkg::LUI:   r = {w[31:12], 12'b0};
            rv_isa_pkg::AUIPC: r = p + {w[31:12], 12'b0};
            rv_isa_pkg::LOAD: begin
                ea = a + imm_i;
                r  = model_mem[ea[11:2]];
            end
            rv_isa_pkg::STORE: begin
                wr = 1'b0;
                if (ea == soc_bus_pkg::HALT_ADDR) begin
                    model_pc = p;
                    return 1'b1;
                end else if (ea == soc_bus_pkg::OUT_ADDR) begin
                    exp_out.push_back(b);
                end else begin
                    model_mem[ea[11:2]] = b;
                end
            end
            rv_isa_pkg::BRANCH: begin
                wr = 1'b0;
                if ((w[14:12] == rv_isa_pkg::BEQ && a == b) ||
                    (w[14:12] == rv_isa_pkg::BNE && a != b)) begin
                    p_next = p + imm_b;
                end
            end
            default: begin
                model_pc = p;
                return 1'b1;
            end
        endcase
        if (wr && w[11:7] != 5'd0) begin
            x[w[11:7]] = r;
        end
        p = p_next;
    end
    model_pc = p;
    return 1'b0;
endfunction

`endif

//--- tb/tb_rv_soc.sv
// testbench for the rv32i soc that loads programs over apb and checks them against a model
`timescale 1ns/100ps

module tb_rv_soc;
    logic               clk;
    logic               rst;
    logic               run;
    logic               psel;
    logic               penable;
    logic               pwrite;
    soc_bus_pkg::addr_t paddr;
    rv_isa_pkg::word_t  pwdata;
    rv_isa_pkg::word_t  prdata;
    logic               pready;
    logic               pslverr;
    rv_isa_pkg::word_t  out_data;
    logic               out_valid;
    logic               halted;
    soc_bus_pkg::addr_t pc;

    int    errors;
    int    timeouts;
    int    out_idx;
    string test_name;

    `include "tb_rv_model.svh"

    rv_soc_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted),
        .pc        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // output compare at the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (out_idx >= exp_out.size()) begin
                $display("** Error [%s] unexpected output, expected none got %h",
                         test_name, out_data);
                errors++;
            end else if (out_data !== exp_out[out_idx]) begin
                $display("** Error [%s] output %0d expected %h got %h",
                         test_name, out_idx, exp_out[out_idx], out_data);
                errors++;
            end
            out_idx++;
        end
    end

    task automatic check_word(input string what, input rv_isa_pkg::word_t exp,
                              input rv_isa_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error [%s] %s expected %h got %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic apb_xfer(input logic wr, input soc_bus_pkg::addr_t a,
                            input rv_isa_pkg::word_t wd, output rv_isa_pkg::word_t rd);
        int n;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= a;
        pwdata  <= wd;
        @(posedge clk);
        penable <= 1'b1;
        rd = 'x;
        for (n = 0; n < 50; n++) begin
            @(negedge clk);
            if (pready) begin
                break;
            end
        end
        if (n == 50) begin
            $display("APB transfer to address %h never got pready", a);
            timeouts++;
        end else begin
            rd = prdata;
            if (pslverr !== 1'b0) begin
                $display("** Error [%s] pslverr expected 0 got %b", test_name, pslverr);
                errors++;
            end
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input soc_bus_pkg::addr_t a, input rv_isa_pkg::word_t wd);
        rv_isa_pkg::word_t dummy;
        apb_xfer(1'b1, a, wd, dummy);
    endtask

    task automatic apb_check(input soc_bus_pkg::addr_t a);
        rv_isa_pkg::word_t rd;
        apb_xfer(1'b0, a, '0, rd);
        check_word($sformatf("apb read %h", a), model_mem[a[11:2]], rd);
    endtask

    // load, run to halt and check outputs, halt state and pc
    task automatic run_program(input string name, input bit contend);
        bit exp_halt;
        int n;
        test_name = name;
        do_reset();
        for (int i = 0; i < prog_len; i++) begin
            apb_write(soc_bus_pkg::addr_t'(i * 4), model_mem[i]);
        end
        exp_halt = run_model();
        out_idx = 0;
        @(posedge clk);
        run <= 1'b1;
        if (contend) begin
            for (int i = 0; i < 4; i++) begin
                apb_check(soc_bus_pkg::addr_t'(i * 4));
            end
            apb_check(32'h0000_0c00);
        end
        for (n = 0; n < 3000; n++) begin
            @(negedge clk);
            if (halted) begin
                break;
            end
        end
        if (n == 3000) begin
            $display("core did not halt in program %s", name);
            timeouts++;
        end
        // no outputs may follow the halt
        repeat (10) @(negedge clk);
        check_word("halted", {31'b0, exp_halt}, {31'b0, halted});
        check_word("output count", exp_out.size(), out_idx);
        check_word("final pc", model_pc, pc);
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic build_alu();
        rv_isa_pkg::word_t a;
        rv_isa_pkg::word_t b;
        rv_isa_pkg::word_t s;
        logic [19:0]       a_hi;
        logic [19:0]       b_hi;
        logic [9:0]        fl [11];
        logic [4:0]        rs2;
        fl = '{rv_isa_pkg::ADD, rv_isa_pkg::SUB, rv_isa_pkg::SLL, rv_isa_pkg::SLT,
               rv_isa_pkg::SLTU, rv_isa_pkg::XOR, rv_isa_pkg::SRL, rv_isa_pkg::SRA,
               rv_isa_pkg::OR, rv_isa_pkg::AND, rv_isa_pkg::MUL};
        a = $urandom | 32'h8000_0000;
        b = $urandom & 32'h7fff_ffff;
        s = $urandom;
        // upper part rounded up when addi sign-extends the low part
        a_hi = a[31:12] + {19'b0, a[11]};
        b_hi = b[31:12] + {19'b0, b[11]};
        prog_len = 0;
        emit(enc_u(rv_isa_pkg::LUI, 5'd1, a_hi));
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd1, 5'd1, a[11:0]));
        emit(enc_u(rv_isa_pkg::LUI, 5'd2, b_hi));
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd2, 5'd2, b[11:0]));
        // odd shift amount so every shift moves bits
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd3, 5'd0, {7'b0, s[4:0] | 5'd1}));
        foreach (fl[i]) begin
            // shifts take the small amount in x3
            rs2 = (fl[i][2:0] == 3'b001 || fl[i][2:0] == 3'b101) ? 5'd3 : 5'd2;
            emit(enc_r(fl[i], 5'd4, 5'd1, rs2));
            emit(enc_s(5'd0, 5'd4, 12'd1000));
        end
        emit(enc_r(rv_isa_pkg::SLT, 5'd4, 5'd2, 5'd1));
        emit(enc_s(5'd0, 5'd4, 12'd1000));
        emit(enc_u(rv_isa_pkg::AUIPC, 5'd4, s[31:12]));
        emit(enc_s(5'd0, 5'd4, 12'd1000));
        emit(enc_s(5'd0, 5'd0, 12'd1004));
    endtask

    task automatic build_ldst();
        rv_isa_pkg::word_t r;
        r = $urandom;
        prog_len = 0;
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd5, 5'd0, 12'd1536));
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd6, 5'd0, r[11:0]));
        emit(enc_s(5'd5, 5'd6, 12'd0));
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd7, 5'd6, r[23:12]));
        emit(enc_s(5'd5, 5'd7, 12'd4));
        emit(enc_i(rv_isa_pkg::LOAD, 3'b010, 5'd8, 5'd5, 12'd0));
        emit(enc_i(rv_isa_pkg::LOAD, 3'b010, 5'd9, 5'd5, 12'd4));
        emit(enc_r(rv_isa_pkg::ADD, 5'd10, 5'd8, 5'd9));
        emit(enc_s(5'd5, 5'd10, 12'd8));
        emit(enc_s(5'd0, 5'd8, 12'd1000));
        emit(enc_s(5'd0, 5'd10, 12'd1000));
        emit(enc_s(5'd0, 5'd0, 12'd1004));
        // never reached
        emit(enc_s(5'd0, 5'd9, 12'd1000));
    endtask

    task automatic build_branch();
        prog_len = 0;
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd1, 5'd0, 12'd5));
        emit(enc_s(5'd0, 5'd1, 12'd1000));
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd1, 5'd1, 12'hfff));
        emit(enc_b(rv_isa_pkg::BNE, 5'd1, 5'd0, 13'h1ff8));
        emit(enc_b(rv_isa_pkg::BEQ, 5'd1, 5'd0, 13'd8));
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd2, 5'd0, 12'd99));
        emit(enc_s(5'd0, 5'd2, 12'd1000));
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd3, 5'd0, 12'd1));
        emit(enc_b(rv_isa_pkg::BEQ, 5'd3, 5'd0, 13'd8));
        emit(enc_s(5'd0, 5'd3, 12'd1000));
        emit(enc_s(5'd0, 5'd0, 12'd1004));
    endtask

    initial begin
        rv_isa_pkg::word_t wv;
        rv_isa_pkg::word_t rd;
        rst      = 1'b1;
        run      = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        errors   = 0;
        timeouts = 0;
        out_idx  = 0;
        void'($urandom(32'h292e_22dc));
        do_reset();

        test_name = "apb_round_trip";
        for (int i = 0; i < 4; i++) begin
            wv = $urandom;
            model_mem[768 + i] = wv;
            apb_write(soc_bus_pkg::addr_t'(32'h0c00 + i * 4), wv);
        end
        for (int i = 0; i < 4; i++) begin
            apb_check(soc_bus_pkg::addr_t'(32'h0c00 + i * 4));
            apb_check(soc_bus_pkg::addr_t'(32'h0c00 + i * 4));
        end

        build_alu();
        run_program("alu", 1'b0);

        build_ldst();
        run_program("load_store", 1'b0);
        test_name = "load_store_mem";
        for (int i = 0; i < 3; i++) begin
            apb_check(soc_bus_pkg::addr_t'(32'h0600 + i * 4));
        end

        build_branch();
        run_program("branch_contention", 1'b1);

        prog_len = 0;
        emit(enc_i(rv_isa_pkg::OPIMM, rv_isa_pkg::ADDI, 5'd1, 5'd0, 12'd7));
        emit(enc_s(5'd0, 5'd1, 12'd1000));
        emit(32'h0000_007f);
        emit(enc_s(5'd0, 5'd1, 12'd1000));
        run_program("unknown_opcode", 1'b0);

        test_name = "apb_after_run";
        apb_xfer(1'b0, 32'h0000_0c00, '0, rd);
        check_word("apb read c00", model_mem[768], rd);

        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
